//--- vlog.f
+incdir+.
colorPkg.sv
ctrlPkg.sv
pixelClockGen.sv
sysLatch.sv
paletteRam.sv
colorOutput.sv
paletteVideoTop.sv
palVideo_props.sv
tbClockGen.sv
tbChecker.sv
tbPaletteVideo.sv

//--- tbPaletteVideo.sv
`timescale 1ns/100ps
`default_nettype none

`include "palVideo_defines.svh"

// Testbench top, drives the palette video path on the falling edge
module tbPaletteVideo;

	localparam int pixDiv = `PIX_DIV;
	localparam int convCount = 64;
	localparam int bankCount = 16;
	localparam int shadeCount = 16;
	localparam int blankCount = 32;
	// Cycle budget of each test
	localparam int lenReset = 4 + 5 * pixDiv;
	localparam int lenConv = 2 * convCount + (convCount + 3) * pixDiv;
	localparam int lenDark = 2 * 4 + (4 + 3) * pixDiv;
	localparam int lenBank = 4 * bankCount + 8 + 2 * (bankCount + 3) * pixDiv;
	localparam int lenShade = 8 + 2 * (shadeCount + 3) * pixDiv;
	localparam int lenBlank = (blankCount + 4) * pixDiv;
	localparam int cycleLimit =
		2 * (lenReset + lenConv + lenDark + lenBank + lenShade + lenBlank) + 100;

	logic CLK_48M, nRESET, latchWrite, palWrite, chbl, bnkb;
	logic hblank, vblank, cePixel;
	ctrlPkg::latchAddr_t latchAddr;
	colorPkg::palIndex_t palIndex, pixIndex;
	colorPkg::palWord_t palWord;
	colorPkg::channel_t red, green, blue;
	logic [31:0] rng;
	colorPkg::palIndex_t convIndex [convCount];
	colorPkg::palIndex_t bankIndex [bankCount];
	int cycleCount;
	int totalErrors;

	tbClockGen #(.period(8), .resetCycles(4)) uClock (.CLK_48M(CLK_48M), .nRESET(nRESET));
	paletteVideoTop u_dut (.*);
	tbChecker uCheck (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic writePalette(input colorPkg::palIndex_t idx, input colorPkg::palWord_t word);
		@(negedge CLK_48M);
		{palWrite, palIndex, palWord} = {1'b1, idx, word};
		@(negedge CLK_48M);
		palWrite = 1'b0;
	endtask

	task automatic writeLatch(input logic [`LATCH_ADDR_W-2:0] sel, input logic val);
		@(negedge CLK_48M);
		{latchWrite, latchAddr} = {1'b1, sel, val};
		@(negedge CLK_48M);
		latchWrite = 1'b0;
	endtask

	// Falling edge inside the strobe cycle
	task automatic waitStrobe(input int count);
		repeat (count) begin
			do @(negedge CLK_48M); while (cePixel !== 1'b1);
		end
	endtask

	// Values are taken at the next strobe
	task automatic showPixel(input colorPkg::palIndex_t idx, input logic c, input logic b);
		waitStrobe(1);
		{pixIndex, chbl, bnkb} = {idx, c, b};
	endtask

	task automatic finishTest(input string name);
		@(negedge CLK_48M);
		#1;
		uCheck.reportTest(name);
	endtask

	//==========================================================================
	// Stimulus
	//==========================================================================

	initial begin : stimulus
		int i;
		{latchWrite, latchAddr, palWrite, palIndex, palWord} = '0;
		{pixIndex, chbl, bnkb} = {12'h000, 1'b0, 1'b1};
		rng = 32'ha70e;
		wait (nRESET === 1'b1);
		repeat (5 * pixDiv) @(negedge CLK_48M);
		finishTest("reset");
		// Random words into bank 0, then shown one per pixel
		for (i = 0; i < convCount; i++) begin
			rng = xorshift(rng);
			convIndex[i] = rng[`PAL_INDEX_W-1:0];
			rng = xorshift(rng);
			writePalette(convIndex[i], rng[15:0]);
		end
		for (i = 0; i < convCount; i++) begin
			showPixel(convIndex[i], 1'b0, 1'b1);
		end
		waitStrobe(2);
		finishTest("convert");
		// Black with dark, white with and without dark, dark with low bits clear
		writePalette(12'hf00, 16'h8000);
		writePalette(12'hf01, 16'hffff);
		writePalette(12'hf02, 16'h7fff);
		writePalette(12'hf03, 16'h8fff);
		for (i = 0; i < 4; i++) begin
			showPixel(12'hf00 + 12'(i), 1'b0, 1'b1);
		end
		waitStrobe(2);
		finishTest("dark");
		// Same indices, own words per bank
		for (i = 0; i < bankCount; i++) begin
			rng = xorshift(rng);
			bankIndex[i] = rng[`PAL_INDEX_W-1:0];
			writePalette(bankIndex[i], rng[31:16]);
		end
		writeLatch(`FLAG_PALBANK, 1'b1);
		for (i = 0; i < bankCount; i++) begin
			rng = xorshift(rng);
			writePalette(bankIndex[i], rng[15:0]);
		end
		for (i = 0; i < 2 * bankCount; i++) begin
			if (i == bankCount) begin
				waitStrobe(2);
				writeLatch(`FLAG_PALBANK, 1'b0);
			end
			showPixel(bankIndex[i % bankCount], 1'b0, 1'b1);
		end
		waitStrobe(2);
		finishTest("bank");
		// Halved channels, then full again
		writeLatch(`FLAG_SHADOW, 1'b1);
		for (i = 0; i < 2 * shadeCount; i++) begin
			if (i == shadeCount) begin
				waitStrobe(2);
				writeLatch(`FLAG_SHADOW, 1'b0);
			end
			showPixel(convIndex[i % shadeCount], 1'b0, 1'b1);
		end
		waitStrobe(2);
		finishTest("shadow");
		for (i = 0; i < blankCount; i++) begin
			rng = xorshift(rng);
			showPixel(convIndex[i], rng[0], rng[1]);
		end
		waitStrobe(3);
		finishTest("blank");
		totalErrors = uCheck.errCount + u_dut.uProps.propFails;
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			uCheck.testsRun, uCheck.testsFailed, uCheck.checkCount, uCheck.errCount,
			u_dut.uProps.propFails);
		if (totalErrors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin : watchdog
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge CLK_48M);
			cycleCount++;
		end
		$display("timeout: run did not end within %0d cycles", cycleLimit);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tbChecker.sv
`timescale 1ns/100ps
`default_nettype none

`include "palVideo_defines.svh"

// Reference model of the colour path
// Follows the write strobes and compares after every pixel strobe
module tbChecker (
	input wire logic CLK_48M,
	input wire logic nRESET,
	input wire logic latchWrite,
	input wire ctrlPkg::latchAddr_t latchAddr,
	input wire logic palWrite,
	input wire colorPkg::palIndex_t palIndex,
	input wire colorPkg::palWord_t palWord,
	input wire colorPkg::palIndex_t pixIndex,
	input wire logic chbl,
	input wire logic bnkb,
	input wire colorPkg::channel_t red,
	input wire colorPkg::channel_t green,
	input wire colorPkg::channel_t blue,
	input wire logic hblank,
	input wire logic vblank,
	input wire logic cePixel
);

	// Palette model, one written flag per word
	colorPkg::palWord_t memModel [2 << `PAL_INDEX_W];
	bit memValid [2 << `PAL_INDEX_W];
	logic [`PAL_INDEX_W:0] addrModel = '0;
	colorPkg::palWord_t wordModel;
	bit addrKnown, wordKnown, expKnown, inReset, pending;
	logic bankModel, shadowModel;
	// Blanking samples of the last two strobes
	logic chbl1, chbl2, bnkb1;
	colorPkg::channel_t expRed, expGreen, expBlue;
	logic expHblank, expVblank;
	int gap, checkCount, errCount, checkMark, errMark, testsRun, testsFailed;

	// Channel 0 red, 1 green, 2 blue
	function automatic colorPkg::channel_t refChannel(
		input colorPkg::palWord_t w,
		input int ch,
		input logic shade
	);
		int nib;
		int level;
		int wide;
		nib = (w >> (8 - 4 * ch)) & 15;
		// Six level steps, nibble MSB fills the bottom
		level = nib * 4 + ((w >> (14 - ch)) & 1) * 2 + nib / 8;
		if (w[15]) begin
			level = (level > 0) ? level - 1 : 0;
		end
		wide = level * 4 + (level / 8) % 4;
		return colorPkg::channel_t'(shade ? wide / 2 : wide);
	endfunction

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errCount++;
			$display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	//==========================================================================
	// Model update on the rising edge, inputs as they were before it
	//==========================================================================

	always @(posedge CLK_48M) begin
		if (!nRESET) begin
			inReset = 1'b1;
			pending = 1'b0;
			bankModel = 1'b0;
			shadowModel = 1'b0;
			addrKnown = 1'b0;
			{chbl1, chbl2, bnkb1} = '0;
			gap = 0;
		end else begin
			inReset = 1'b0;
			// Strobe spacing
			if (cePixel && gap != `PIX_DIV) begin
				errCount++;
				$display("cePixel at %0t came %0d cycles after the previous one", $time, gap);
			end else if (!cePixel && gap == `PIX_DIV) begin
				errCount++;
				$display("cePixel missing at %0t after %0d cycles", $time, gap);
			end
			gap = cePixel ? 1 : gap + 1;
			if (cePixel) begin
				checkCount++;
				// Outputs loaded from last pixel's word, current shadow
				expKnown = wordKnown;
				expRed = refChannel(wordModel, 0, shadowModel);
				expGreen = refChannel(wordModel, 1, shadowModel);
				expBlue = refChannel(wordModel, 2, shadowModel);
				expVblank = ~bnkb1;
				expHblank = chbl2;
				chbl2 = chbl1;
				chbl1 = chbl;
				bnkb1 = bnkb;
				pending = 1'b1;
			end
			// Read word trails the captured address by a cycle
			wordKnown = addrKnown && memValid[addrModel];
			wordModel = memModel[addrModel];
			if (cePixel) begin
				addrModel = {bankModel, pixIndex};
				addrKnown = 1'b1;
			end
			// Writes use the bank in force before any latch change
			if (palWrite) begin
				memModel[{bankModel, palIndex}] = palWord;
				memValid[{bankModel, palIndex}] = 1'b1;
			end
			if (latchWrite && latchAddr[`LATCH_ADDR_W-1:1] == `FLAG_SHADOW) begin
				shadowModel = latchAddr[0];
			end
			if (latchWrite && latchAddr[`LATCH_ADDR_W-1:1] == `FLAG_PALBANK) begin
				bankModel = latchAddr[0];
			end
		end
	end

	// Outputs settle after the rising edge, compare on the falling one
	always @(negedge CLK_48M) begin
		if (inReset) begin
			compareValue("red", 0, red);
			compareValue("green", 0, green);
			compareValue("blue", 0, blue);
			compareValue("hblank", 0, hblank);
			compareValue("vblank", 0, vblank);
			compareValue("cePixel", 0, cePixel);
		end else if (pending) begin
			pending = 1'b0;
			// Unwritten palette words have no defined colour
			if (expKnown) begin
				compareValue("red", expRed, red);
				compareValue("green", expGreen, green);
				compareValue("blue", expBlue, blue);
			end
			compareValue("hblank", expHblank, hblank);
			compareValue("vblank", expVblank, vblank);
		end
	end

	// One line per finished test
	task automatic reportTest(input string name);
		int checks;
		int errs;
		checks = checkCount - checkMark;
		errs = errCount - errMark;
		if (checks == 0) begin
			errCount++;
			errs++;
			$display("test %s compared nothing", name);
		end
		testsRun++;
		if (errs != 0) begin
			testsFailed++;
		end
		$display("test %-8s %0d checks, %0d errors", name, checks, errs);
		checkMark = checkCount;
		errMark = errCount;
	endtask

endmodule

`default_nettype wire

//--- tbClockGen.sv
`timescale 1ns/100ps
`default_nettype none

// Free running master clock and a reset held for a few rising edges
module tbClockGen #(
	parameter int period = 8,
	parameter int resetCycles = 4
) (
	output logic CLK_48M,
	output logic nRESET
);

	initial begin
		CLK_48M = 1'b0;
		forever #(period / 2) CLK_48M = ~CLK_48M;
	end

	// Release away from the rising edge
	initial begin
		nRESET = 1'b0;
		repeat (resetCycles) @(posedge CLK_48M);
		@(negedge CLK_48M);
		nRESET = 1'b1;
	end

endmodule

`default_nettype wire

//--- palVideo_props.sv
`timescale 1ns/100ps
`default_nettype none

`include "palVideo_defines.svh"

// Protocol assertions on the pixel strobe and the reset state
module palVideoProps (
	input wire logic CLK_48M,
	input wire logic nRESET,
	input wire logic cePixel,
	input wire colorPkg::channel_t red,
	input wire colorPkg::channel_t green,
	input wire colorPkg::channel_t blue,
	input wire logic hblank,
	input wire logic vblank
);

	// Number of failed assertions
	int propFails = 0;

	// Strobe is one cycle wide
	strobeWidth: assert property (@(posedge CLK_48M) disable iff (!nRESET)
		cePixel |=> !cePixel)
		else begin
			propFails++;
			$error("cePixel stayed high for more than one cycle");
		end

	// Next strobe exactly PIX_DIV cycles later
	strobePeriod: assert property (@(posedge CLK_48M) disable iff (!nRESET)
		cePixel |=> (!cePixel) [*(`PIX_DIV - 1)] ##1 cePixel)
		else begin
			propFails++;
			$error("cePixel did not repeat after PIX_DIV cycles");
		end

	// Everything cleared one edge into reset
	resetClear: assert property (@(posedge CLK_48M)
		!nRESET |=> (red == '0 && green == '0 && blue == '0
			&& !hblank && !vblank && !cePixel))
		else begin
			propFails++;
			$error("outputs not cleared while nRESET is low");
		end

endmodule

bind paletteVideoTop palVideoProps uProps (
	.CLK_48M(CLK_48M),
	.nRESET(nRESET),
	.cePixel(cePixel),
	.red(red),
	.green(green),
	.blue(blue),
	.hblank(hblank),
	.vblank(vblank)
);

`default_nettype wire

//--- paletteVideoTop.sv
`timescale 1ns/100ps
`default_nettype none

`include "palVideo_defines.svh"

//==========================================================================
// Palette video top level
//==========================================================================

// Colour path of the NeoGeo video
// Latch flags steer the palette RAM and the output stage
// Index sampled at one pixel strobe shows its colour at the next
module paletteVideoTop (
	input wire logic CLK_48M,
	input wire logic nRESET,
	// System latch write strobe
	input wire logic latchWrite,
	input wire ctrlPkg::latchAddr_t latchAddr,
	// Palette write strobe
	input wire logic palWrite,
	input wire colorPkg::palIndex_t palIndex,
	input wire colorPkg::palWord_t palWord,
	// Per pixel video inputs, taken on cePixel
	input wire colorPkg::palIndex_t pixIndex,
	input wire logic chbl,
	input wire logic bnkb,
	// Video out
	output colorPkg::channel_t red,
	output colorPkg::channel_t green,
	output colorPkg::channel_t blue,
	output logic hblank,
	output logic vblank,
	output logic cePixel
);

	// Pixel strobe shared by RAM read and output stage
	logic pixEn;

	// Latch flags
	logic shadow;
	ctrlPkg::palBank_t palBank;

	// Palette word for the pixel in flight
	colorPkg::palWord_t rdWord;

	pixelClockGen uPixClk (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.pixEn(pixEn)
	);

	sysLatch uSysLatch (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.latchWrite(latchWrite),
		.latchAddr(latchAddr),
		.shadow(shadow),
		.palBank(palBank)
	);

	// Bank select applies to both ports
	paletteRam uPalRam (
		.CLK_48M(CLK_48M),
		.palWrite(palWrite),
		.palIndex(palIndex),
		.palWord(palWord),
		.palBank(palBank),
		.pixEn(pixEn),
		.pixIndex(pixIndex),
		.rdWord(rdWord)
	);

	colorOutput uColorOut (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.pixEn(pixEn),
		.rdWord(rdWord),
		.shadow(shadow),
		.chbl(chbl),
		.bnkb(bnkb),
		.red(red),
		.green(green),
		.blue(blue),
		.hblank(hblank),
		.vblank(vblank)
	);

	// Pixel enable for the scaler / video sink
	assign cePixel = pixEn;

endmodule

`default_nettype wire

//--- colorOutput.sv
`timescale 1ns/100ps
`default_nettype none

`include "palVideo_defines.svh"

//==========================================================================
// Colour output stage
//==========================================================================

// Turns the palette word into 24-bit RGB
// Applies shadow and lines the blanking up with the colour
module colorOutput (
	input wire logic CLK_48M,
	input wire logic nRESET,
	input wire logic pixEn,
	input wire colorPkg::palWord_t rdWord,
	input wire logic shadow,
	input wire logic chbl,
	input wire logic bnkb,
	output colorPkg::channel_t red,
	output colorPkg::channel_t green,
	output colorPkg::channel_t blue,
	output logic hblank,
	output logic vblank
);

	// Expand one channel
	// hi is the upper nibble, lo the shared low bit from 14..12
	function automatic colorPkg::channel_t expandChan(
		input logic [3:0] hi,
		input logic lo,
		input logic dark,
		input logic shade
	);
		logic [6:0] v6;
		colorPkg::channel_t v8;
		// 6-bit value, nibble then low bit then nibble MSB again
		// Dark bit takes one step off, extra bit catches the underflow
		v6 = {1'b0, hi, lo, hi[3]} - 7'(dark);
		// Clamp at black, else widen by repeating bits 4 and 3
		v8 = v6[6] ? '0 : {v6[5:0], v6[4:3]};
		// Shadow halves the channel
		return shade ? {1'b0, v8[`CHAN_W-1:1]} : v8;
	endfunction

	//==========================================================================
	// Combinational conversion
	//==========================================================================

	colorPkg::channel_t redNext;
	colorPkg::channel_t greenNext;
	colorPkg::channel_t blueNext;

	// Dark bit is shared by all three channels
	assign redNext = expandChan(rdWord[11:8], rdWord[14], rdWord[15], shadow);
	assign greenNext = expandChan(rdWord[7:4], rdWord[13], rdWord[15], shadow);
	assign blueNext = expandChan(rdWord[3:0], rdWord[12], rdWord[15], shadow);

	//==========================================================================
	// Output registers
	//==========================================================================

	// Blanking samples taken at the pixel strobe
	logic chblQ;
	logic chblQ2;
	logic bnkbQ;

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			red <= '0;
			green <= '0;
			blue <= '0;
			hblank <= 1'b0;
			vblank <= 1'b0;
			chblQ <= 1'b0;
			chblQ2 <= 1'b0;
			bnkbQ <= 1'b0;
		end else if (pixEn) begin
			// Word from the previous strobe, shadow as it is now
			red <= redNext;
			green <= greenNext;
			blue <= blueNext;
			// bnkb is active low, so vblank is its inverse
			bnkbQ <= bnkb;
			vblank <= ~bnkbQ;
			// chbl runs one pixel further behind than bnkb
			chblQ <= chbl;
			chblQ2 <= chblQ;
			hblank <= chblQ2;
		end
	end

endmodule

`default_nettype wire

//--- paletteRam.sv
`timescale 1ns/100ps
`default_nettype none

`include "palVideo_defines.svh"

//==========================================================================
// Palette RAM
//==========================================================================

// Two banks of colour words
// CPU writes at any cycle, video reads once per pixel
module paletteRam (
	input wire logic CLK_48M,
	input wire logic palWrite,
	input wire colorPkg::palIndex_t palIndex,
	input wire colorPkg::palWord_t palWord,
	input wire ctrlPkg::palBank_t palBank,
	input wire logic pixEn,
	input wire colorPkg::palIndex_t pixIndex,
	output colorPkg::palWord_t rdWord
);

	// Bank bit on top of the index
	localparam int addrW = `PAL_INDEX_W + 1;
	localparam int ramDepth = 1 << addrW;

	colorPkg::palWord_t palMem [ramDepth];

	// Read address held for the whole pixel
	logic [addrW-1:0] rdAddr;

	// CPU port, write only
	// The bank follows the latch at the moment of the write
	always_ff @(posedge CLK_48M) begin
		if (palWrite) begin
			palMem[{palBank, palIndex}] <= palWord;
		end
	end

	// Video port
	// Address captured on the pixel strobe, data one cycle behind
	always_ff @(posedge CLK_48M) begin
		if (pixEn) begin
			rdAddr <= {palBank, pixIndex};
		end
		// Same-cycle write to this word is seen one cycle later
		rdWord <= palMem[rdAddr];
	end

endmodule

`default_nettype wire

//--- sysLatch.sv
`timescale 1ns/100ps
`default_nettype none

`include "palVideo_defines.svh"

//==========================================================================
// System latch
//==========================================================================

// Addressable bit latch written by the CPU
// Only shadow and palette bank are kept here
module sysLatch (
	input wire logic CLK_48M,
	input wire logic nRESET,
	input wire logic latchWrite,
	input wire ctrlPkg::latchAddr_t latchAddr,
	output logic shadow,
	output ctrlPkg::palBank_t palBank
);

	// Flag select field is the address without the data bit
	localparam int selW = `LATCH_ADDR_W - 1;

	localparam logic [selW-1:0] selShadow = selW'(`FLAG_SHADOW);
	localparam logic [selW-1:0] selPalBank = selW'(`FLAG_PALBANK);

	// Decoded write fields
	logic [selW-1:0] flagSel;
	logic flagVal;

	assign flagSel = latchAddr[`LATCH_ADDR_W-1:1];
	assign flagVal = latchAddr[0];

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			// Power up with full brightness and bank 0
			shadow <= 1'b0;
			palBank <= 1'b0;
		end else if (latchWrite) begin
			// One flag per strobe takes effect on the next cycle
			case (flagSel)
				selShadow: begin
					shadow <= flagVal;
				end
				selPalBank: begin
					palBank <= flagVal;
				end
				default: begin
					// Other selects are not stored in this latch
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- pixelClockGen.sv
`timescale 1ns/100ps
`default_nettype none

`include "palVideo_defines.svh"

// Pixel clock enable
// One pulse every PIX_DIV master cycles, phase fixed by reset
module pixelClockGen (
	input wire logic CLK_48M,
	input wire logic nRESET,
	output logic pixEn
);

	localparam int cntW = $clog2(`PIX_DIV);
	localparam logic [cntW-1:0] lastCount = cntW'(`PIX_DIV - 1);

	// Position inside the current pixel
	logic [cntW-1:0] pixCnt;

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			// Count restarts so the first pulse lands on the eighth edge
			pixCnt <= '0;
			pixEn <= 1'b0;
		end else begin
			// Registered strobe, high for exactly one cycle
			pixEn <= (pixCnt == lastCount);
			if (pixCnt == lastCount) begin
				pixCnt <= '0;
			end else begin
				pixCnt <= pixCnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- ctrlPkg.sv
`default_nettype none

`include "palVideo_defines.svh"

//==========================================================================
// CPU side types
//==========================================================================

package ctrlPkg;

	// System latch address
	// Upper three bits select one flag, bit 0 is the value stored
	typedef logic [`LATCH_ADDR_W-1:0] latchAddr_t;

	// Palette bank select, one bit for two banks
	typedef logic palBank_t;

endpackage

`default_nettype wire

//--- colorPkg.sv
`default_nettype none

`include "palVideo_defines.svh"

//==========================================================================
// Pixel side types
//==========================================================================

package colorPkg;

	// Index into one palette bank
	// The bank bit comes from the system latch, not from the pixel
	typedef logic [`PAL_INDEX_W-1:0] palIndex_t;

	// NeoGeo colour word as stored in palette RAM
	// Bit 15 dark bit
	// Bits 14, 13, 12 low bits of red, green, blue
	// Bits 11..8 red, 7..4 green, 3..0 blue (upper four bits each)
	typedef logic [`PAL_WORD_W-1:0] palWord_t;

	// One expanded output channel
	typedef logic [`CHAN_W-1:0] channel_t;

endpackage

`default_nettype wire

//--- palVideo_defines.svh
`ifndef PAL_VIDEO_DEFINES_SVH
`define PAL_VIDEO_DEFINES_SVH

//==========================================================================
// Palette video widths and constants
//==========================================================================

// Palette index inside one bank
// Two banks of 4096 entries make the 8192 word palette RAM
`define PAL_INDEX_W 12

// NeoGeo colour word
`define PAL_WORD_W 16

// One RGB output channel
`define CHAN_W 8

// Master clock cycles per pixel
// 48 MHz divided by 8 gives the 6 MHz dot clock
`define PIX_DIV 8

// System latch address
// Upper bits pick the flag, bit 0 carries the written value
`define LATCH_ADDR_W 4

// Flag selects held by the latch
`define FLAG_SHADOW 0
`define FLAG_PALBANK 7

`endif
